/* project.f */
src/mem_stage_pkg.sv
src/rep_control.sv
src/rep_counter.sv
src/addr_stepper.sv
src/data_ram.sv
src/mem_stage.sv
test/tb_clock_gen.sv
test/mem_stage_assertions.sv
test/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module mem_stage_tb \
    && ./obj_dir/Vmem_stage_tb | tee /dev/stderr | grep -qx "=== PASS ===" \
    || { echo "simulation did not pass"; exit 1; }

/* src/addr_stepper.sv */
`timescale 1ns/1ns

module addr_stepper import mem_stage_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        load,
    input  logic        step,
    input  mem_req_t    req,
    output logic [31:0] src_addr,
    output logic [31:0] dst_addr,
    output logic        in_range,
    output logic [31:0] fault_addr
);

    // one past the last RAM element, 33 bits so a full 32-bit space still fits
    localparam logic [32:0] depth = 33'd1 << addr_width;

    logic        dir_q;
    logic [31:0] limit_q;
    logic [31:0] incdec;
    logic [32:0] eff_limit;
    logic        src_ok;
    logic        dst_ok;

    // +1 or -1 per element
    assign incdec = dir_q ? 32'hffff_ffff : 32'h0000_0001;

    always_ff @(posedge clk) begin
        if (reset) begin
            src_addr <= '0;
            dst_addr <= '0;
            dir_q    <= 1'b0;
            limit_q  <= '0;
        end else if (load) begin
            src_addr <= req.src_addr;
            dst_addr <= req.dst_addr;
            dir_q    <= req.dir;
            limit_q  <= req.limit;
        end else if (step) begin
            src_addr <= src_addr + incdec;
            dst_addr <= dst_addr + incdec;
        end
    end

    // a segment never reaches past the physical RAM
    assign eff_limit = ({1'b0, limit_q} > depth) ? depth : {1'b0, limit_q};

    // stepping below zero wraps to a huge address, which fails here too
    assign src_ok   = ({1'b0, src_addr} < eff_limit);
    assign dst_ok   = ({1'b0, dst_addr} < eff_limit);
    assign in_range = src_ok && dst_ok;

    // source side is reported first
    assign fault_addr = src_ok ? dst_addr : src_addr;

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ns

module data_ram import mem_stage_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic                  clk,
    input  logic                  rd_en,
    input  logic [31:0]           rd_addr,
    input  logic                  wr_en,
    input  logic [31:0]           wr_addr,
    output logic [data_width-1:0] rd_data,
    input  logic                  host_we,
    input  logic [31:0]           host_addr,
    input  logic [data_width-1:0] host_wdata,
    output logic [data_width-1:0] host_rdata
);

    localparam int depth = 1 << addr_width;

    logic [data_width-1:0] mem [depth];

    // move write takes the element read in the cycle before
    // host writes only happen while the stage is idle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[addr_width-1:0]] <= rd_data;
        end else if (host_we) begin
            mem[host_addr[addr_width-1:0]] <= host_wdata;
        end
    end

    // both read paths are registered, data one cycle after the address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[addr_width-1:0]];
        end
        host_rdata <= mem[host_addr[addr_width-1:0]];
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import mem_stage_pkg::*; #(
    parameter int addr_width = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        valid_in,
    input  mem_req_t    req,
    output logic        stall,
    output logic        done,
    output mem_resp_t   resp,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    output logic [31:0] host_rdata
);

    logic        load;
    logic        step;
    logic        rd_en;
    logic        wr_en;
    logic        empty;
    logic        in_range;
    logic        fault;
    logic [31:0] count_in;
    logic [31:0] moved;
    logic [31:0] src_addr;
    logic [31:0] dst_addr;
    logic [31:0] fault_addr;
    logic [31:0] dst_addr_q;

    // a non-rep move is a single element
    assign count_in = req.is_rep ? req.count : 32'd1;

    // destination lines up with the registered read data
    always_ff @(posedge clk) begin
        dst_addr_q <= dst_addr;
    end

    rep_control u_control (
        .clk      (clk),
        .reset    (reset),
        .valid_in (valid_in),
        .empty    (empty),
        .in_range (in_range),
        .load     (load),
        .step     (step),
        .rd_en    (rd_en),
        .wr_en    (wr_en),
        .finish   (done),
        .stall    (stall)
    );

    rep_counter u_counter (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .step     (step),
        .count_in (count_in),
        .moved    (moved),
        .empty    (empty)
    );

    addr_stepper #(.addr_width(addr_width)) u_stepper (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step       (step),
        .req        (req),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .in_range   (in_range),
        .fault_addr (fault_addr)
    );

    data_ram #(.addr_width(addr_width)) u_ram (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_addr    (src_addr),
        .wr_en      (wr_en),
        .wr_addr    (dst_addr_q),
        .rd_data    (),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    // counter and addresses hold after the stop, so a stop with work left is a fault
    assign fault = !empty && !in_range;

    always_comb begin
        resp.moved      = moved;
        resp.fault      = fault;
        resp.fault_addr = fault ? fault_addr : 32'd0;
        resp.src_end    = src_addr;
        resp.dst_end    = dst_addr;
    end

endmodule

/* src/mem_stage_pkg.sv */
package mem_stage_pkg;

    // width of one string element
    localparam int data_width = 32;

    // one string-move request, captured on acceptance
    typedef struct packed {
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
        logic [31:0] count;
        // 0 steps up, 1 steps down
        logic        dir;
        logic        is_rep;
        // segment size, first illegal address
        logic [31:0] limit;
    } mem_req_t;

    // result, valid only in the done cycle
    typedef struct packed {
        // elements written
        logic [31:0] moved;
        logic        fault;
        // failing address, zero when no fault
        logic [31:0] fault_addr;
        // addresses after the last move
        logic [31:0] src_end;
        logic [31:0] dst_end;
    } mem_resp_t;

    typedef enum logic [1:0] {
        idle,
        run,
        drain,
        finish
    } rep_state_t;

endpackage

/* src/rep_control.sv */
`timescale 1ns/1ns

module rep_control import mem_stage_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic valid_in,
    input  logic empty,
    input  logic in_range,
    output logic load,
    output logic step,
    output logic rd_en,
    output logic wr_en,
    output logic finish,
    output logic stall
);

    rep_state_t state;
    rep_state_t state_next;
    logic       issue;

    // one element per cycle while work is left and both addresses pass the limit
    assign issue = (state == run) && !empty && in_range;

    // stall is low only in idle, so valid_in alone accepts there
    assign load  = (state == idle) && valid_in;
    assign step  = issue;
    assign rd_en = issue;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (valid_in) begin
                    state_next = run;
                end
            end
            run: begin
                // count exhausted or protection fault
                if (!issue) begin
                    state_next = drain;
                end
            end
            drain: begin
                // last write has landed, counter and addresses are frozen
                state_next = mem_stage_pkg::finish;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            wr_en <= 1'b0;
        end else begin
            state <= state_next;
            // write follows its read by one cycle
            wr_en <= rd_en;
        end
    end

    assign stall  = (state != idle);
    // result cycle, stall drops at the same edge as this
    assign finish = (state == mem_stage_pkg::finish);

endmodule

/* src/rep_counter.sv */
`timescale 1ns/1ns

module rep_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        load,
    input  logic        step,
    input  logic [31:0] count_in,
    output logic [31:0] moved,
    output logic        empty
);

    logic [31:0] remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
            moved     <= '0;
        end else if (load) begin
            remaining <= count_in;
            moved     <= '0;
        end else if (step) begin
            // one element issued, it is written in the next cycle
            remaining <= remaining - 32'd1;
            moved     <= moved + 32'd1;
        end
    end

    // nothing left to issue
    assign empty = (remaining == 32'd0);

endmodule

/* test/mem_stage_assertions.sv */
`timescale 1ns/1ns

module mem_stage_assertions (
    input logic        clk,
    input logic        reset,
    input logic        valid_in,
    input logic        stall,
    input logic        done,
    input logic        host_we,
    input logic [31:0] host_addr
);

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // stall falls at the same edge as done
    stall_drops_with_done: assert property (@(posedge clk) disable iff (reset) done |=> !stall)
        else $error("stall stayed high after the done cycle");

    // stage comes out of reset idle
    idle_after_reset: assert property (@(posedge clk) reset |=> !stall && !done)
        else $error("stall or done high right after reset");

    stall_after_accept: assert property (@(posedge clk) disable iff (reset)
        valid_in && !stall |=> stall)
        else $error("stall did not rise after an accepted request");

    // host port belongs to the idle stage only
    host_quiet: assert property (@(posedge clk) disable iff (reset)
        stall |-> !host_we && $stable(host_addr))
        else $error("host port used while stall was high");

endmodule

/* test/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int addr_width = 8;
    localparam int depth = 1 << addr_width;

    logic                  clk, reset, valid_in, stall, done, host_we;
    logic [31:0]           host_addr, host_wdata, host_rdata;
    mem_req_t              req;
    mem_resp_t             resp;
    mem_resp_t             expected_resp;
    logic [data_width-1:0] shadow [depth];
    mem_req_t              tests [$];
    bit                    pulse_flags [$];
    integer                seed = 32'h7e70_4ca3;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    done_count = 0;
    int                    cycle_limit = 0;
    int                    cycle_count = 0;

    tb_clock_gen u_clock (.clk(clk), .reset(reset));

    mem_stage #(.addr_width(addr_width)) dut (
        .clk(clk), .reset(reset), .valid_in(valid_in), .req(req), .stall(stall),
        .done(done), .resp(resp), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata)
    );

    bind mem_stage mem_stage_assertions u_assertions (
        .clk(clk), .reset(reset), .valid_in(valid_in), .stall(stall), .done(done),
        .host_we(host_we), .host_addr(host_addr)
    );

    function automatic logic [31:0] rand_below(input logic [31:0] span);
        logic [31:0] r;
        r = $random(seed);
        return r % span;
    endfunction

    // sequential copy in the shadow RAM, stopping at the first address past the limit
    function automatic mem_resp_t model_move(input mem_req_t r);
        mem_resp_t   res;
        logic [31:0] n, src, dst, delta;
        logic        src_bad, dst_bad;
        res   = '0;
        n     = r.is_rep ? r.count : 32'd1;
        src   = r.src_addr;
        dst   = r.dst_addr;
        delta = r.dir ? 32'hffff_ffff : 32'd1;
        while (res.moved < n && !res.fault) begin
            src_bad = (src >= r.limit);
            dst_bad = (dst >= r.limit);
            if (src_bad || dst_bad) begin
                res.fault      = 1'b1;
                res.fault_addr = src_bad ? src : dst;
            end else begin
                shadow[dst[addr_width-1:0]] = shadow[src[addr_width-1:0]];
                src       = src + delta;
                dst       = dst + delta;
                res.moved = res.moved + 32'd1;
            end
        end
        res.src_end = src;
        res.dst_end = dst;
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        value_errors = value_errors + 1;
        $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
    endtask

    task automatic check_resp(input mem_resp_t got, input mem_resp_t exp);
        if (got.moved !== exp.moved) report_mismatch("resp.moved", exp.moved, got.moved);
        if (got.fault !== exp.fault) report_mismatch("resp.fault", exp.fault, got.fault);
        if (got.fault_addr !== exp.fault_addr)
            report_mismatch("resp.fault_addr", exp.fault_addr, got.fault_addr);
        if (got.src_end !== exp.src_end) report_mismatch("resp.src_end", exp.src_end, got.src_end);
        if (got.dst_end !== exp.dst_end) report_mismatch("resp.dst_end", exp.dst_end, got.dst_end);
    endtask

    task automatic check_word(input int index, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
        if (got !== exp) report_mismatch($sformatf("host_rdata[%0d]", index), exp, got);
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) report_mismatch("done latency", exp, got);
    endtask

    task automatic add_test(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] count, input logic dir, input logic is_rep,
                            input logic [31:0] limit, input bit pulse);
        mem_req_t r;
        r.src_addr = src;
        r.dst_addr = dst;
        r.count    = count;
        r.dir      = dir;
        r.is_rep   = is_rep;
        r.limit    = limit;
        tests.push_back(r);
        pulse_flags.push_back(pulse);
    endtask

    // source below 128 and destination above, so the ranges never overlap
    task automatic build_tests();
        for (int i = 0; i < 2; i++) begin
            add_test(rand_below(100), 128 + rand_below(100), $random(seed), i[0], 0, 256, 0);
        end
        for (int i = 0; i < 3; i++) begin
            add_test(rand_below(60), 128 + rand_below(60), 1 + rand_below(40), 0, 1, 256, 0);
        end
        for (int i = 0; i < 3; i++) begin
            add_test(40 + rand_below(60), 168 + rand_below(60), 1 + rand_below(40), 1, 1, 256, 0);
        end
        add_test(rand_below(100), 128 + rand_below(100), 0, 0, 1, 256, 0);
        // faults on destination, source, source wrapping below zero, first element
        add_test(10, 180, 40, 0, 1, 200, 0);
        add_test(150, 20, 30, 0, 1, 160, 0);
        add_test(5, 200, 20, 1, 1, 256, 0);
        add_test(220, 10, 8, 0, 1, 200, 0);
        add_test(rand_below(60), 128 + rand_below(60), 12, 0, 1, 256, 1);
    endtask

    task automatic fill_ram();
        logic [31:0] word;
        for (int i = 0; i < depth; i++) begin
            @(negedge clk);
            word       = $random(seed);
            host_we    = 1'b1;
            host_addr  = i;
            host_wdata = word;
            shadow[i]  = word;
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    // host read data trails its address by one cycle
    task automatic read_back();
        host_addr = 32'd0;
        for (int i = 0; i < depth; i++) begin
            @(negedge clk);
            check_word(i, host_rdata, shadow[i]);
            host_addr = i + 1;
        end
    endtask

    task automatic run_test(input mem_req_t r, input bit pulse);
        mem_req_t decoy;
        int       n;
        int       cycles;
        expected_resp  = model_move(r);
        n              = expected_resp.moved;
        // a swapped copy would show up in the RAM if it were accepted
        decoy          = r;
        decoy.src_addr = r.dst_addr;
        decoy.dst_addr = r.src_addr;
        @(negedge clk);
        valid_in = 1'b1;
        req      = r;
        @(negedge clk);
        valid_in = 1'b0;
        req      = decoy;
        cycles   = 0;
        while (!done && cycles < n + 2) begin
            if (pulse) valid_in = !valid_in;
            @(negedge clk);
            cycles = cycles + 1;
        end
        valid_in = 1'b0;
        if (!done) begin
            other_errors = other_errors + 1;
            $display("done did not arrive within %0d cycles of acceptance", n + 2);
        end else begin
            check_latency(cycles, n + 2);
        end
        @(negedge clk);
        read_back();
    endtask

    task automatic finish_run();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // result check in the done cycle
    always @(negedge clk) begin
        if (!reset && done) begin
            done_count = done_count + 1;
            check_resp(resp, expected_resp);
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        other_errors = other_errors + 1;
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        finish_run();
    end

    initial begin
        int limit;
        valid_in   = 1'b0;
        req        = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        build_tests();
        // reset and fill, then count + 2 + depth + 10 per test
        limit = 10 + depth + 10;
        foreach (tests[i]) begin
            limit = limit + (tests[i].is_rep ? tests[i].count : 32'd1) + 2 + depth + 10;
        end
        cycle_limit = limit;
        wait (reset === 1'b0);
        fill_ram();
        foreach (tests[i]) begin
            run_test(tests[i], pulse_flags[i]);
        end
        if (done_count != tests.size()) begin
            other_errors = other_errors + 1;
            $display("saw %0d done pulses for %0d requests", done_count, tests.size());
        end
        finish_run();
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ten cycles of reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
